// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;
  localparam int NREG   = 32;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_SYSTEM = 7'b1110011,
    OPC_FENCE  = 7'b0001111
  } opcode_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_e;

  typedef enum logic {
    DEC_IDLE,
    DEC_WAIT
  } dec_state_e;

  typedef struct packed {
    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
  } issue_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   op_a;       // ALU operands
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   rs1_val;    // Branch compare operands
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   jump_base;
    logic [XLEN-1:0]   imm;
    alu_op_e           alu_op;
    logic [REG_AW-1:0] rd;
    logic              rd_wen;
    logic              is_branch;
    logic              is_jump;
    logic [2:0]        br_funct3;
    logic              illegal;
  } dec_t;

  // Shared by the execute register and the retire port
  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic              rd_wen;
    logic [XLEN-1:0]   wdata;
    logic [XLEN-1:0]   next_pc;
    logic              illegal;
  } retire_t;

endpackage

`default_nettype wire

// File: hw/rv_regfile.sv
`default_nettype none
`timescale 1ns/100ps

module rv_regfile import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic [REG_AW-1:0] rs1_addr_i,
  input  logic [REG_AW-1:0] rs2_addr_i,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o,
  input  logic              wb_en_i,
  input  logic [REG_AW-1:0] wb_addr_i,
  input  logic [XLEN-1:0]   wb_data_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:NREG-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NREG; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_en_i && wb_addr_i != '0) begin
      regs_q[wb_addr_i] <= wb_data_i;
    end
  end

  // No write bypass; the busy scoreboard covers it
  always_comb begin
    if (rs1_addr_i == '0)
      rs1_data_o = '0;
    else
      rs1_data_o = regs_q[rs1_addr_i];

    if (rs2_addr_i == '0)
      rs2_data_o = '0;
    else
      rs2_data_o = regs_q[rs2_addr_i];
  end

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
`default_nettype none
`timescale 1ns/100ps

module rv_decode import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              issue_valid_i,
  input  issue_t            issue_i,
  output logic              issue_ready_o,
  output logic [REG_AW-1:0] rs1_addr_o,
  output logic [REG_AW-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  input  logic              wb_en_i,
  input  logic [REG_AW-1:0] wb_addr_i,
  output logic              dec_valid_o,
  output dec_t              dec_o,
  input  logic              exe_ready_i
);

  dec_state_e        state_q;
  dec_t              dec_d;
  dec_t              dec_q;
  logic [NREG-1:0]   busy_q;
  logic [NREG-1:0]   busy_d;
  opcode_e           opcode;
  logic [REG_AW-1:0] rs1, rs2, rd;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [XLEN-1:0]   imm_i, imm_b, imm_u, imm_j;
  logic              uses_rs1, uses_rs2;
  logic              hazard;
  logic              accept;

  assign opcode = opcode_e'(issue_i.inst[6:0]);
  assign rd     = issue_i.inst[11:7];
  assign funct3 = issue_i.inst[14:12];
  assign rs1    = issue_i.inst[19:15];
  assign rs2    = issue_i.inst[24:20];
  assign funct7 = issue_i.inst[31:25];

  assign imm_i = {{20{issue_i.inst[31]}}, issue_i.inst[31:20]};
  assign imm_b = {{19{issue_i.inst[31]}}, issue_i.inst[31], issue_i.inst[7],
                  issue_i.inst[30:25], issue_i.inst[11:8], 1'b0};
  assign imm_u = {issue_i.inst[31:12], 12'b0};
  assign imm_j = {{11{issue_i.inst[31]}}, issue_i.inst[31], issue_i.inst[19:12],
                  issue_i.inst[20], issue_i.inst[30:21], 1'b0};

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  // Operands resolved from the live issue word
  always_comb begin
    dec_d           = '0;
    dec_d.pc        = issue_i.pc;
    dec_d.rs1_val   = rs1_data_i;
    dec_d.rs2_val   = rs2_data_i;
    dec_d.rd        = rd;
    dec_d.br_funct3 = funct3;
    dec_d.alu_op    = ALU_ADD;
    uses_rs1        = 1'b0;
    uses_rs2        = 1'b0;
    case (opcode)
      OPC_LUI: begin
        dec_d.op_b   = imm_u;
        dec_d.imm    = imm_u;
        dec_d.rd_wen = 1'b1;
      end
      OPC_AUIPC: begin
        dec_d.op_a   = issue_i.pc;
        dec_d.op_b   = imm_u;
        dec_d.imm    = imm_u;
        dec_d.rd_wen = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        dec_d.op_a    = issue_i.pc;      // Link value pc + 4
        dec_d.op_b    = 32'd4;
        dec_d.rd_wen  = 1'b1;
        dec_d.is_jump = 1'b1;
        if (opcode == OPC_JAL) begin
          dec_d.jump_base = issue_i.pc;
          dec_d.imm       = imm_j;
        end else begin
          dec_d.jump_base = rs1_data_i;
          dec_d.imm       = imm_i;
          uses_rs1        = 1'b1;
        end
      end
      OPC_BRANCH: begin
        dec_d.jump_base = issue_i.pc;
        dec_d.imm       = imm_b;
        dec_d.is_branch = 1'b1;
        uses_rs1        = 1'b1;
        uses_rs2        = 1'b1;
      end
      OPC_OP_IMM: begin
        dec_d.op_a   = rs1_data_i;
        dec_d.op_b   = imm_i;
        dec_d.imm    = imm_i;
        dec_d.alu_op = alu_op_e'({(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3});
        dec_d.rd_wen = 1'b1;
        uses_rs1     = 1'b1;
      end
      OPC_OP: begin
        dec_d.op_a   = rs1_data_i;
        dec_d.op_b   = rs2_data_i;
        dec_d.alu_op = alu_op_e'({funct7[5], funct3});
        dec_d.rd_wen = 1'b1;
        uses_rs1     = 1'b1;
        uses_rs2     = 1'b1;
      end
      OPC_LOAD, OPC_STORE, OPC_SYSTEM, OPC_FENCE: dec_d.illegal = 1'b1;
      default: dec_d.illegal = 1'b1;
    endcase
  end

  // Also waits out an older pending write to rd
  assign hazard = (uses_rs1 && busy_q[rs1]) || (uses_rs2 && busy_q[rs2]) ||
                  (dec_d.rd_wen && busy_q[rd]);

  assign issue_ready_o = (state_q == DEC_IDLE) && !hazard;
  assign accept        = issue_valid_i && issue_ready_o;

  always_comb begin
    busy_d = busy_q;
    if (wb_en_i)
      busy_d[wb_addr_i] = 1'b0;
    if (accept && dec_d.rd_wen)
      busy_d[rd] = 1'b1;
    busy_d[0] = 1'b0;   // x0 never pending
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= DEC_IDLE;
      busy_q  <= '0;
    end else begin
      busy_q <= busy_d;
      case (state_q)
        DEC_IDLE: if (accept) state_q <= DEC_WAIT;
        DEC_WAIT: if (exe_ready_i) state_q <= DEC_IDLE;
        default:  state_q <= DEC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      dec_q <= dec_d;
  end

  assign dec_valid_o = (state_q == DEC_WAIT);
  assign dec_o       = dec_q;

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
`default_nettype none
`timescale 1ns/100ps

module rv_execute import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    dec_valid_i,
  input  dec_t    dec_i,
  output logic    exe_ready_o,
  output logic    exe_valid_o,
  output retire_t exe_o,
  input  logic    res_ready_i
);

  logic [XLEN-1:0] alu_res;
  logic [4:0]      shamt;
  logic            taken;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] next_pc;
  logic            exe_valid_q;
  retire_t         exe_q;

  assign shamt = dec_i.op_b[4:0];

  always_comb begin
    case (dec_i.alu_op)
      ALU_ADD:  alu_res = dec_i.op_a + dec_i.op_b;
      ALU_SUB:  alu_res = dec_i.op_a - dec_i.op_b;
      ALU_SLL:  alu_res = dec_i.op_a << shamt;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(dec_i.op_a) < $signed(dec_i.op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, dec_i.op_a < dec_i.op_b};
      ALU_XOR:  alu_res = dec_i.op_a ^ dec_i.op_b;
      ALU_SRL:  alu_res = dec_i.op_a >> shamt;
      ALU_SRA:  alu_res = $signed(dec_i.op_a) >>> shamt;
      ALU_OR:   alu_res = dec_i.op_a | dec_i.op_b;
      ALU_AND:  alu_res = dec_i.op_a & dec_i.op_b;
      default:  alu_res = dec_i.op_a + dec_i.op_b;
    endcase
  end

  always_comb begin
    case (dec_i.br_funct3)
      3'b000:  taken = dec_i.rs1_val == dec_i.rs2_val;                    // BEQ
      3'b001:  taken = dec_i.rs1_val != dec_i.rs2_val;                    // BNE
      3'b100:  taken = $signed(dec_i.rs1_val) < $signed(dec_i.rs2_val);   // BLT
      3'b101:  taken = $signed(dec_i.rs1_val) >= $signed(dec_i.rs2_val);  // BGE
      3'b110:  taken = dec_i.rs1_val < dec_i.rs2_val;                     // BLTU
      3'b111:  taken = dec_i.rs1_val >= dec_i.rs2_val;                    // BGEU
      default: taken = 1'b0;
    endcase
  end

  assign target = dec_i.jump_base + dec_i.imm;

  always_comb begin
    // Bit 0 clear is a no-op for JAL with an aligned pc
    if (dec_i.is_jump)
      next_pc = {target[XLEN-1:1], 1'b0};
    else if (dec_i.is_branch && taken)
      next_pc = target;
    else
      next_pc = dec_i.pc + 32'd4;
  end

  assign exe_ready_o = !exe_valid_q || res_ready_i;

  always_ff @(posedge clk) begin
    if (rst)
      exe_valid_q <= 1'b0;
    else if (dec_valid_i && exe_ready_o)
      exe_valid_q <= 1'b1;
    else if (res_ready_i)
      exe_valid_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (dec_valid_i && exe_ready_o) begin
      exe_q.pc      <= dec_i.pc;
      exe_q.rd      <= dec_i.rd;
      exe_q.rd_wen  <= dec_i.rd_wen && !dec_i.is_branch && !dec_i.illegal;
      exe_q.wdata   <= alu_res;
      exe_q.next_pc <= next_pc;
      exe_q.illegal <= dec_i.illegal;
    end
  end

  assign exe_valid_o = exe_valid_q;
  assign exe_o       = exe_q;

endmodule

`default_nettype wire

// File: hw/rv_result.sv
`default_nettype none
`timescale 1ns/100ps

module rv_result import rv_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              exe_valid_i,
  input  retire_t           exe_i,
  output logic              res_ready_o,
  output logic              wb_en_o,
  output logic [REG_AW-1:0] wb_addr_o,
  output logic [XLEN-1:0]   wb_data_o,
  output logic              retire_valid_o,
  output retire_t           retire_o,
  input  logic              retire_ready_i
);

  logic    take;
  logic    ret_valid_q;
  retire_t ret_q;

  assign res_ready_o = !ret_valid_q || retire_ready_i;
  assign take        = exe_valid_i && res_ready_o;

  // Write on acceptance so a stalled retire port still frees dependents
  assign wb_en_o   = take && exe_i.rd_wen && (exe_i.rd != '0);
  assign wb_addr_o = exe_i.rd;
  assign wb_data_o = exe_i.wdata;

  always_ff @(posedge clk) begin
    if (rst)
      ret_valid_q <= 1'b0;
    else if (take)
      ret_valid_q <= 1'b1;
    else if (retire_ready_i)
      ret_valid_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (take)
      ret_q <= exe_i;
  end

  assign retire_valid_o = ret_valid_q;
  assign retire_o       = ret_q;

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`default_nettype none
`timescale 1ns/100ps

module rv_core import rv_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    issue_valid_i,
  input  issue_t  issue_i,
  output logic    issue_ready_o,
  output logic    retire_valid_o,
  output retire_t retire_o,
  input  logic    retire_ready_i
);

  logic [REG_AW-1:0] rs1_addr, rs2_addr;
  logic [XLEN-1:0]   rs1_data, rs2_data;
  logic              wb_en;
  logic [REG_AW-1:0] wb_addr;
  logic [XLEN-1:0]   wb_data;
  logic              dec_valid, exe_ready;
  dec_t              dec_data;
  logic              exe_valid, res_ready;
  retire_t           exe_data;

  rv_decode u_rv_decode (
    .clk           (clk),
    .rst           (rst),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .issue_ready_o (issue_ready_o),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .wb_en_i       (wb_en),      // Scoreboard release
    .wb_addr_i     (wb_addr),
    .dec_valid_o   (dec_valid),
    .dec_o         (dec_data),
    .exe_ready_i   (exe_ready)
  );

  rv_regfile u_rv_regfile (
    .clk        (clk),
    .rst        (rst),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_en_i    (wb_en),
    .wb_addr_i  (wb_addr),
    .wb_data_i  (wb_data)
  );

  rv_execute u_rv_execute (
    .clk         (clk),
    .rst         (rst),
    .dec_valid_i (dec_valid),
    .dec_i       (dec_data),
    .exe_ready_o (exe_ready),
    .exe_valid_o (exe_valid),
    .exe_o       (exe_data),
    .res_ready_i (res_ready)
  );

  rv_result u_rv_result (
    .clk            (clk),
    .rst            (rst),
    .exe_valid_i    (exe_valid),
    .exe_i          (exe_data),
    .res_ready_o    (res_ready),
    .wb_en_o        (wb_en),
    .wb_addr_o      (wb_addr),
    .wb_data_o      (wb_data),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o),
    .retire_ready_i (retire_ready_i)
  );

endmodule

`default_nettype wire

// File: sim/rv_core_tb.sv
`default_nettype none
`timescale 1ns/100ps

module rv_core_tb import rv_pkg::*; ();

  logic    clk;
  logic    rst;
  logic    issue_valid;
  issue_t  issue;
  logic    issue_ready;
  logic    retire_valid;
  retire_t retire;
  logic    retire_ready;

  issue_t      stim_q[$];
  retire_t     expect_q[$];
  logic [31:0] row_pc;
  int          pass_no;
  int          max_wait = 50;

  rv_core u_rv_core (
    .clk            (clk),
    .rst            (rst),
    .issue_valid_i  (issue_valid),
    .issue_i        (issue),
    .issue_ready_o  (issue_ready),
    .retire_valid_o (retire_valid),
    .retire_o       (retire),
    .retire_ready_i (retire_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Instruction encoders
  function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] btype(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] utype(input logic [6:0] opc, input logic [4:0] rd,
                                        input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] jtype(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic push_row(input logic [31:0] inst, input logic [4:0] rd, input logic wen,
                          input logic [31:0] wdata, input logic [31:0] npc, input logic ill);
    stim_q.push_back('{inst, row_pc});
    expect_q.push_back('{row_pc, rd, wen, wdata, npc, ill});
    row_pc = row_pc + 32'd4;
  endtask

  task automatic alu_row(input logic [31:0] inst, input logic [4:0] rd,
                         input logic [31:0] wdata);
    push_row(inst, rd, 1'b1, wdata, row_pc + 32'd4, 1'b0);
  endtask

  task automatic jump_row(input logic [31:0] inst, input logic [4:0] rd,
                          input logic [31:0] target);
    push_row(inst, rd, 1'b1, row_pc + 32'd4, target, 1'b0);  // Link value
  endtask

  // off is the taken offset, or 4 when not taken
  task automatic branch_row(input logic [31:0] inst, input int off);
    push_row(inst, 5'd0, 1'b0, 32'd0, row_pc + off, 1'b0);
  endtask

  task automatic illegal_row(input logic [31:0] inst);
    push_row(inst, 5'd0, 1'b0, 32'd0, row_pc + 32'd4, 1'b1);
  endtask

  task automatic build_table();
    row_pc = 32'h100;
    alu_row(itype(7'h13, 3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
    alu_row(itype(7'h13, 3'b000, 5'd2, 5'd0, 12'hffd), 5'd2, 32'hffff_fffd);
    alu_row(rtype(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'd2);            // ADD
    alu_row(rtype(7'h20, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, 32'd8);            // SUB
    alu_row(itype(7'h13, 3'b001, 5'd5, 5'd1, 12'd3), 5'd5, 32'd40);          // SLLI
    alu_row(itype(7'h13, 3'b101, 5'd6, 5'd2, 12'h401), 5'd6, 32'hffff_fffe); // SRAI
    alu_row(itype(7'h13, 3'b101, 5'd7, 5'd2, 12'd28), 5'd7, 32'h0000_000f);  // SRLI
    alu_row(rtype(7'h20, 3'b101, 5'd8, 5'd2, 5'd1), 5'd8, 32'hffff_ffff);    // SRA
    alu_row(rtype(7'h00, 3'b010, 5'd9, 5'd2, 5'd1), 5'd9, 32'd1);            // SLT
    alu_row(rtype(7'h00, 3'b011, 5'd10, 5'd2, 5'd1), 5'd10, 32'd0);          // SLTU
    alu_row(itype(7'h13, 3'b010, 5'd11, 5'd2, 12'd0), 5'd11, 32'd1);         // SLTI
    alu_row(itype(7'h13, 3'b011, 5'd12, 5'd1, 12'hfff), 5'd12, 32'd1);       // SLTIU
    alu_row(itype(7'h13, 3'b100, 5'd13, 5'd1, 12'h00f), 5'd13, 32'd10);      // XORI
    alu_row(rtype(7'h00, 3'b110, 5'd14, 5'd1, 5'd4), 5'd14, 32'd13);         // OR
    alu_row(rtype(7'h00, 3'b111, 5'd15, 5'd2, 5'd1), 5'd15, 32'd5);          // AND
    alu_row(itype(7'h13, 3'b000, 5'd0, 5'd1, 12'd7), 5'd0, 32'd12);          // Dropped
    alu_row(rtype(7'h00, 3'b000, 5'd16, 5'd0, 5'd1), 5'd16, 32'd5);
    alu_row(utype(7'b0110111, 5'd17, 20'h12345), 5'd17, 32'h1234_5000);
    alu_row(utype(7'b0010111, 5'd18, 20'h00001), 5'd18, row_pc + 32'h1000);
    jump_row(jtype(5'd19, 21'd16), 5'd19, row_pc + 32'd16);
    alu_row(itype(7'h13, 3'b000, 5'd20, 5'd0, 12'h201), 5'd20, 32'h201);
    jump_row(itype(7'b1100111, 3'b000, 5'd21, 5'd20, 12'd6), 5'd21, 32'h206);
    // x1 = 5, x2 = -3, x4 = 8
    branch_row(btype(3'b000, 5'd1, 5'd1, 13'd8), 8);
    branch_row(btype(3'b000, 5'd1, 5'd4, 13'd8), 4);
    branch_row(btype(3'b001, 5'd1, 5'd4, 13'h1ff8), -8);
    branch_row(btype(3'b001, 5'd1, 5'd1, 13'h1ff8), 4);
    branch_row(btype(3'b100, 5'd2, 5'd1, 13'd12), 12);
    branch_row(btype(3'b100, 5'd1, 5'd2, 13'd12), 4);
    branch_row(btype(3'b101, 5'd1, 5'd2, 13'd16), 16);
    branch_row(btype(3'b101, 5'd2, 5'd1, 13'd16), 4);
    branch_row(btype(3'b110, 5'd1, 5'd2, 13'd20), 20);
    branch_row(btype(3'b110, 5'd2, 5'd1, 13'd20), 4);
    branch_row(btype(3'b111, 5'd2, 5'd1, 13'd24), 24);
    branch_row(btype(3'b111, 5'd1, 5'd4, 13'd24), 4);
    // Dependent chain
    alu_row(itype(7'h13, 3'b000, 5'd22, 5'd0, 12'd1), 5'd22, 32'd1);
    alu_row(itype(7'h13, 3'b000, 5'd22, 5'd22, 12'd2), 5'd22, 32'd3);
    alu_row(itype(7'h13, 3'b000, 5'd22, 5'd22, 12'd3), 5'd22, 32'd6);
    alu_row(rtype(7'h00, 3'b000, 5'd23, 5'd22, 5'd22), 5'd23, 32'd12);
    illegal_row(itype(7'b0000011, 3'b010, 5'd24, 5'd1, 12'd0));  // LW
    illegal_row(itype(7'b0100011, 3'b010, 5'd8, 5'd1, 12'd0));   // SW
    illegal_row(32'h0000_0073);
    illegal_row(32'h0000_007f);
    alu_row(itype(7'h13, 3'b000, 5'd25, 5'd23, 12'd1), 5'd25, 32'd13);
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_val(input int i, input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else
      abort_run($sformatf("CHECK FAILED at time %0t: pass %0d row %0d %s is %h, expected %h",
                          $time, pass_no, i, name, got, exp));
  endtask

  function automatic logic next_ready(input bit stall);
    return stall ? (($urandom % 4) != 0) : 1'b1;
  endfunction

  task automatic issue_rows();
    int waited;
    for (int i = 0; i < stim_q.size(); i++) begin
      issue_valid = 1'b1;
      issue       = stim_q[i];
      waited      = 0;
      @(negedge clk);
      while (!issue_ready) begin
        waited++;
        if (waited > max_wait)
          abort_run($sformatf("Timeout: issue of row %0d was never accepted", i));
        @(negedge clk);
      end
      @(posedge clk);
      #2;
    end
    issue_valid = 1'b0;
  endtask

  task automatic check_rows(input bit stall);
    int      waited;
    retire_t got;
    retire_t exp;
    for (int i = 0; i < expect_q.size(); i++) begin
      waited = 0;
      @(negedge clk);
      while (!(retire_valid && retire_ready)) begin
        waited++;
        if (waited > max_wait)
          abort_run($sformatf("Timeout: no retire record for row %0d", i));
        @(posedge clk);
        #2;
        retire_ready = next_ready(stall);
        @(negedge clk);
      end
      got = retire;
      exp = expect_q[i];
      check_val(i, "pc", got.pc, exp.pc);  // Catches loss and reorder
      check_val(i, "rd_wen", 32'(got.rd_wen), 32'(exp.rd_wen));
      check_val(i, "illegal", 32'(got.illegal), 32'(exp.illegal));
      check_val(i, "next_pc", got.next_pc, exp.next_pc);
      if (exp.rd_wen) begin
        check_val(i, "rd", 32'(got.rd), 32'(exp.rd));
        check_val(i, "wdata", got.wdata, exp.wdata);
      end
      @(posedge clk);
      #2;
      retire_ready = next_ready(stall);
    end
  endtask

  initial begin
    void'($urandom(32'h3950b8c8));
    rst          = 1'b1;
    issue_valid  = 1'b0;
    issue        = '0;
    retire_ready = 1'b1;
    pass_no      = 0;
    build_table();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;

    fork
      begin
        for (int p = 0; p < 2; p++)
          issue_rows();
      end
      begin
        for (int p = 0; p < 2; p++) begin
          pass_no = p;
          check_rows(p == 1);  // Second pass with retire back-pressure
        end
      end
    join

    // Nothing left over, so no duplicates
    retire_ready = 1'b1;
    repeat (10) begin
      @(negedge clk);
      assert (!retire_valid) else
        abort_run($sformatf("CHECK FAILED at time %0t: extra retire record, pc %h",
                            $time, retire.pc));
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
sim/rv_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module rv_core_tb \
  -f flist.f --Mdir obj_dir -o rv_core_tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rv_core_tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
echo "Simulation PASSED"
exit 0
